// File: rtl/llc_settings.svh
`ifndef LLC_SETTINGS_SVH
`define LLC_SETTINGS_SVH

`define LLC_MSG_W      24
`define LLC_FIFO_DEPTH 4
`define LLC_SETS       16
`define LLC_SET_W      4
`define LLC_KIND_W     3

// output kinds carried on out_kind
`define KIND_REQ_ACK      3'd0
`define KIND_RECALL_START 3'd1
`define KIND_RECALL_DONE  3'd2
`define KIND_RST_DONE     3'd3
`define KIND_DMA_RD_BEAT  3'd4
`define KIND_DMA_WR_ACK   3'd5

`endif

// File: rtl/llc_pkg.sv
`include "llc_settings.svh"

package llc_pkg;

    // ******************************
    // request and response word
    // ******************************

    // op encodes 0 read, 1 write, 2 recall
    typedef struct packed {
        logic [1:0]            op;
        logic [`LLC_SET_W-1:0] set;
        logic [9:0]            tag;
        logic [7:0]            data;
    } llc_req_view_t;

    // ******************************
    // DMA word
    // ******************************

    // beats holds the beat count minus one
    typedef struct packed {
        logic                  write;
        logic [2:0]            beats;
        logic [`LLC_SET_W-1:0] set;
        logic [7:0]            pad;
        logic [7:0]            data;
    } llc_dma_view_t;

    // the engine picks the view from the channel that was selected
    typedef union packed {
        llc_req_view_t req;
        llc_dma_view_t dma;
    } llc_msg_u;

endpackage

// File: rtl/llc_dispatch_if.sv
`timescale 1ns/1ns

interface llc_dispatch_if import llc_pkg::*; ();
    logic     decode_en;
    logic     recall_pending, recall_valid;
    logic     dma_read_pending, dma_write_pending;
    logic     rst_stall, req_stall, req_in_stalled_valid;
    logic     is_dma_read_to_resume, is_dma_write_to_resume;
    logic     is_rst_to_get, is_rsp_to_get, is_req_to_get, is_dma_req_to_get;
    logic     is_rst_to_resume, look;
    logic     set_is_dma_read_to_resume, clr_is_dma_read_to_resume;
    logic     set_is_dma_write_to_resume, clr_is_dma_write_to_resume;
    logic     update_req_in_from_stalled, clr_req_in_stalled_valid;
    llc_msg_u msg;

    modport decoder (
        input  decode_en, recall_pending, recall_valid, dma_read_pending, dma_write_pending,
        input  rst_stall, req_stall, req_in_stalled_valid,
        input  is_dma_read_to_resume, is_dma_write_to_resume,
        output is_rst_to_get, is_rsp_to_get, is_req_to_get, is_dma_req_to_get,
        output is_rst_to_resume, look, msg,
        output set_is_dma_read_to_resume, clr_is_dma_read_to_resume,
        output set_is_dma_write_to_resume, clr_is_dma_write_to_resume,
        output update_req_in_from_stalled, clr_req_in_stalled_valid
    );

    modport engine (
        output decode_en, recall_pending, recall_valid, dma_read_pending, dma_write_pending,
        output rst_stall, req_stall, req_in_stalled_valid,
        output is_dma_read_to_resume, is_dma_write_to_resume,
        input  is_rst_to_get, is_rsp_to_get, is_req_to_get, is_dma_req_to_get,
        input  is_rst_to_resume, look, msg,
        input  set_is_dma_read_to_resume, clr_is_dma_read_to_resume,
        input  set_is_dma_write_to_resume, clr_is_dma_write_to_resume,
        input  update_req_in_from_stalled, clr_req_in_stalled_valid
    );
endinterface

// File: rtl/llc_in_fifo.sv
`timescale 1ns/1ns
`include "llc_settings.svh"

module llc_in_fifo #(
    parameter int WIDTH = `LLC_MSG_W,
    parameter int DEPTH = `LLC_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push, pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/llc_input_decoder.sv
`timescale 1ns/1ns
`include "llc_settings.svh"

module llc_input_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rst_cmd_valid,
    output logic                  rst_cmd_ready,
    input  logic                  rsp_valid,
    output logic                  rsp_ready,
    input  logic [`LLC_MSG_W-1:0] rsp_data,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [`LLC_MSG_W-1:0] req_data,
    input  logic                  dma_valid,
    output logic                  dma_ready,
    input  logic [`LLC_MSG_W-1:0] dma_data,
    llc_dispatch_if.decoder       disp
);

    logic rst_get_next, rsp_get_next, req_get_next, dma_req_get_next, rst_resume_next;

    // ******************************
    // priority selection
    // ******************************

    always_comb begin
        rst_get_next                    = 1'b0;
        rsp_get_next                    = 1'b0;
        req_get_next                    = 1'b0;
        dma_req_get_next                = 1'b0;
        rst_resume_next                 = 1'b0;
        req_ready                       = 1'b0;
        dma_ready                       = 1'b0;
        disp.set_is_dma_read_to_resume  = 1'b0;
        disp.set_is_dma_write_to_resume = 1'b0;
        disp.clr_is_dma_read_to_resume  = 1'b0;
        disp.clr_is_dma_write_to_resume = 1'b0;
        disp.update_req_in_from_stalled = 1'b0;
        disp.clr_req_in_stalled_valid   = 1'b0;
        if (disp.decode_en) begin
            // resume flags live for one decision only
            disp.clr_is_dma_read_to_resume  = 1'b1;
            disp.clr_is_dma_write_to_resume = 1'b1;
            if (disp.recall_pending) begin
                if (!disp.recall_valid) begin
                    rsp_get_next = rsp_valid;
                end else if (disp.dma_read_pending) begin
                    disp.set_is_dma_read_to_resume = 1'b1;
                end else if (disp.dma_write_pending) begin
                    disp.set_is_dma_write_to_resume = 1'b1;
                end
            end else if (disp.rst_stall) begin
                rst_resume_next = 1'b1;
            end else if (rst_cmd_valid && !disp.dma_read_pending && !disp.dma_write_pending) begin
                rst_get_next = 1'b1;
            end else if (rsp_valid) begin
                rsp_get_next = 1'b1;
            end else if (!disp.req_stall && (disp.req_in_stalled_valid || req_valid)) begin
                // a held request always goes ahead of a new one
                if (disp.req_in_stalled_valid) begin
                    disp.update_req_in_from_stalled = 1'b1;
                    disp.clr_req_in_stalled_valid   = 1'b1;
                end else begin
                    req_ready = 1'b1;
                end
                req_get_next = 1'b1;
            end else if (disp.dma_read_pending) begin
                disp.set_is_dma_read_to_resume = 1'b1;
            end else if (disp.dma_write_pending) begin
                if (dma_valid) begin
                    disp.set_is_dma_write_to_resume = 1'b1;
                    dma_ready = 1'b1;
                end
            end else if (dma_valid && !disp.req_stall) begin
                dma_req_get_next = 1'b1;
                dma_ready = 1'b1;
            end
        end
    end

    assign rst_cmd_ready = rst_get_next;
    assign rsp_ready     = rsp_get_next;

    // ******************************
    // registered dispatch
    // ******************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            disp.is_rst_to_get     <= 1'b0;
            disp.is_rsp_to_get     <= 1'b0;
            disp.is_req_to_get     <= 1'b0;
            disp.is_dma_req_to_get <= 1'b0;
            disp.is_rst_to_resume  <= 1'b0;
        end else if (disp.decode_en) begin
            disp.is_rst_to_get     <= rst_get_next;
            disp.is_rsp_to_get     <= rsp_get_next;
            disp.is_req_to_get     <= req_get_next;
            disp.is_dma_req_to_get <= dma_req_get_next;
            disp.is_rst_to_resume  <= rst_resume_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_ready) begin
            disp.msg <= rsp_data;
        end else if (req_ready) begin
            disp.msg <= req_data;
        end else if (dma_ready) begin
            disp.msg <= dma_data;
        end
    end

    // a DMA resume waits while a recall is still open
    assign disp.look = disp.is_rsp_to_get | disp.is_req_to_get | disp.is_dma_req_to_get |
                       (disp.is_dma_read_to_resume & ~disp.recall_pending) |
                       (disp.is_dma_write_to_resume & ~disp.recall_pending);

endmodule

// File: rtl/llc_engine.sv
`timescale 1ns/1ns
`include "llc_settings.svh"

module llc_engine import llc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    llc_dispatch_if.engine         disp,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LLC_KIND_W-1:0] out_kind,
    output logic [`LLC_SET_W+7:0]  out_data
);

    localparam logic [`LLC_SET_W-1:0] LAST_SET = `LLC_SET_W'(`LLC_SETS - 1);

    logic [7:0]             set_tbl [`LLC_SETS];
    logic                   exec, use_stalled, recall_active;
    logic [`LLC_SET_W-1:0]  recall_set, dma_addr, rst_cnt, tbl_addr;
    logic [2:0]             dma_left;
    llc_req_view_t          stalled_req, req_w;
    llc_dma_view_t          dma_w;
    logic                   look_exec, act_recall_done, act_rsp, act_req, act_stall;
    logic                   act_dma_cmd, act_dma_rd, act_dma_wr, act_rst_cmd, act_rst_step;
    logic                   tbl_we, out_load;
    logic [7:0]             tbl_wdata;
    logic [`LLC_KIND_W-1:0] kind_next;
    logic [`LLC_SET_W+7:0]  data_next;

    assign req_w     = use_stalled ? stalled_req : disp.msg.req;
    assign dma_w     = disp.msg.dma;
    assign look_exec = exec & disp.look;

    assign act_recall_done = exec & disp.recall_pending & disp.recall_valid;
    assign act_rsp         = look_exec & disp.is_rsp_to_get;
    assign act_req         = look_exec & disp.is_req_to_get;
    assign act_stall       = act_req & recall_active & (req_w.set == recall_set) &
                             (req_w.op != 2'd2);
    assign act_dma_cmd     = look_exec & disp.is_dma_req_to_get;
    assign act_dma_rd      = look_exec & disp.is_dma_read_to_resume;
    assign act_dma_wr      = look_exec & disp.is_dma_write_to_resume;
    assign act_rst_cmd     = exec & disp.is_rst_to_get;
    assign act_rst_step    = exec & disp.is_rst_to_resume;

    // ******************************
    // execute, table write and result
    // ******************************

    always_comb begin
        tbl_we    = 1'b0;
        tbl_addr  = req_w.set;
        tbl_wdata = req_w.data;
        out_load  = 1'b0;
        kind_next = `KIND_REQ_ACK;
        data_next = {req_w.set, set_tbl[req_w.set]};
        if (act_recall_done) begin
            out_load  = 1'b1;
            kind_next = `KIND_RECALL_DONE;
            data_next = {recall_set, set_tbl[recall_set]};
        end else if (act_rsp && recall_active) begin
            // with nothing stalled behind it the recall finishes right here
            tbl_we    = 1'b1;
            tbl_addr  = recall_set;
            tbl_wdata = disp.msg.req.data;
            out_load  = !disp.recall_pending;
            kind_next = `KIND_RECALL_DONE;
            data_next = {recall_set, disp.msg.req.data};
        end else if (act_req && !act_stall) begin
            out_load = 1'b1;
            if (req_w.op == 2'd1) begin
                tbl_we    = 1'b1;
                data_next = {req_w.set, req_w.data};
            end else if (req_w.op == 2'd2) begin
                kind_next = `KIND_RECALL_START;
            end
        end else if (act_dma_cmd && !dma_w.write) begin
            out_load  = 1'b1;
            kind_next = `KIND_DMA_RD_BEAT;
            data_next = {dma_w.set, set_tbl[dma_w.set]};
        end else if (act_dma_rd) begin
            out_load  = 1'b1;
            kind_next = `KIND_DMA_RD_BEAT;
            data_next = {dma_addr, set_tbl[dma_addr]};
        end else if (act_dma_wr) begin
            tbl_we    = 1'b1;
            tbl_addr  = dma_addr;
            tbl_wdata = dma_w.data;
            out_load  = (dma_left == 3'd0);
            kind_next = `KIND_DMA_WR_ACK;
            data_next = {dma_addr, dma_w.data};
        end else if (act_rst_step) begin
            tbl_we    = 1'b1;
            tbl_addr  = rst_cnt;
            tbl_wdata = 8'd0;
            out_load  = (rst_cnt == LAST_SET);
            kind_next = `KIND_RST_DONE;
            data_next = {rst_cnt, 8'd0};
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            set_tbl[tbl_addr] <= tbl_wdata;
        end
        if (act_stall) begin
            stalled_req <= req_w;
        end
        if (out_load) begin
            out_kind <= kind_next;
            out_data <= data_next;
        end
    end

    // ******************************
    // control state
    // ******************************

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            disp.decode_en              <= 1'b0;
            disp.recall_pending         <= 1'b0;
            disp.recall_valid           <= 1'b0;
            disp.dma_read_pending       <= 1'b0;
            disp.dma_write_pending      <= 1'b0;
            disp.rst_stall              <= 1'b0;
            disp.req_stall              <= 1'b0;
            disp.req_in_stalled_valid   <= 1'b0;
            disp.is_dma_read_to_resume  <= 1'b0;
            disp.is_dma_write_to_resume <= 1'b0;
            exec          <= 1'b0;
            use_stalled   <= 1'b0;
            recall_active <= 1'b0;
            recall_set    <= '0;
            dma_addr      <= '0;
            dma_left      <= '0;
            rst_cnt       <= '0;
            out_valid     <= 1'b0;
        end else begin
            // one decision at a time, and only into an empty output register
            disp.decode_en <= !disp.decode_en && !exec && (!out_valid || out_ready);
            exec <= disp.decode_en;
            if (out_load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (disp.decode_en) begin
                use_stalled <= disp.update_req_in_from_stalled;
            end
            if (disp.set_is_dma_read_to_resume) begin
                disp.is_dma_read_to_resume <= 1'b1;
            end else if (disp.clr_is_dma_read_to_resume) begin
                disp.is_dma_read_to_resume <= 1'b0;
            end
            if (disp.set_is_dma_write_to_resume) begin
                disp.is_dma_write_to_resume <= 1'b1;
            end else if (disp.clr_is_dma_write_to_resume) begin
                disp.is_dma_write_to_resume <= 1'b0;
            end
            if (disp.clr_req_in_stalled_valid) begin
                disp.req_in_stalled_valid <= 1'b0;
            end
            if (act_recall_done) begin
                disp.recall_pending <= 1'b0;
                disp.recall_valid   <= 1'b0;
                disp.req_stall      <= 1'b0;
                recall_active       <= 1'b0;
            end
            if (act_rsp && recall_active) begin
                if (disp.recall_pending) begin
                    disp.recall_valid <= 1'b1;
                end else begin
                    recall_active <= 1'b0;
                end
            end
            if (act_req && req_w.op == 2'd2) begin
                recall_active <= 1'b1;
                recall_set    <= req_w.set;
            end
            if (act_stall) begin
                disp.req_in_stalled_valid <= 1'b1;
                disp.req_stall            <= 1'b1;
                disp.recall_pending       <= 1'b1;
            end
            if (act_dma_cmd) begin
                // a read sends its first beat with the command itself
                if (dma_w.write) begin
                    disp.dma_write_pending <= 1'b1;
                    dma_addr <= dma_w.set;
                    dma_left <= dma_w.beats;
                end else begin
                    disp.dma_read_pending <= (dma_w.beats != 3'd0);
                    dma_addr <= dma_w.set + 1'b1;
                    dma_left <= dma_w.beats - 3'd1;
                end
            end
            if (act_dma_rd || act_dma_wr) begin
                dma_addr <= dma_addr + 1'b1;
                dma_left <= dma_left - 3'd1;
                if (dma_left == 3'd0) begin
                    disp.dma_read_pending  <= 1'b0;
                    disp.dma_write_pending <= 1'b0;
                end
            end
            if (act_rst_cmd) begin
                disp.rst_stall <= 1'b1;
                rst_cnt        <= '0;
            end
            if (act_rst_step) begin
                rst_cnt <= rst_cnt + 1'b1;
                if (rst_cnt == LAST_SET) begin
                    disp.rst_stall <= 1'b0;
                end
            end
        end
    end

endmodule

// File: rtl/llc_front.sv
`timescale 1ns/1ns
`include "llc_settings.svh"

module llc_front (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rst_cmd_valid,
    output logic                   rst_cmd_ready,
    input  logic                   rsp_valid,
    output logic                   rsp_ready,
    input  logic [`LLC_MSG_W-1:0]  rsp_data,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic [`LLC_MSG_W-1:0]  req_data,
    input  logic                   dma_valid,
    output logic                   dma_ready,
    input  logic [`LLC_MSG_W-1:0]  dma_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LLC_KIND_W-1:0] out_kind,
    output logic [`LLC_SET_W+7:0]  out_data
);

    logic                  rsp_q_valid, rsp_q_ready;
    logic                  req_q_valid, req_q_ready;
    logic                  dma_q_valid, dma_q_ready;
    logic [`LLC_MSG_W-1:0] rsp_q_data, req_q_data, dma_q_data;

    llc_dispatch_if disp ();

    llc_in_fifo #(.WIDTH(`LLC_MSG_W)) u_rsp_fifo (
        .clk(clk), .rst(rst),
        .in_valid(rsp_valid), .in_ready(rsp_ready), .in_data(rsp_data),
        .out_valid(rsp_q_valid), .out_ready(rsp_q_ready), .out_data(rsp_q_data)
    );

    llc_in_fifo #(.WIDTH(`LLC_MSG_W)) u_req_fifo (
        .clk(clk), .rst(rst),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req_data),
        .out_valid(req_q_valid), .out_ready(req_q_ready), .out_data(req_q_data)
    );

    llc_in_fifo #(.WIDTH(`LLC_MSG_W)) u_dma_fifo (
        .clk(clk), .rst(rst),
        .in_valid(dma_valid), .in_ready(dma_ready), .in_data(dma_data),
        .out_valid(dma_q_valid), .out_ready(dma_q_ready), .out_data(dma_q_data)
    );

    // the reset command has no payload and goes straight to the decoder
    llc_input_decoder u_decoder (
        .clk(clk), .rst(rst),
        .rst_cmd_valid(rst_cmd_valid), .rst_cmd_ready(rst_cmd_ready),
        .rsp_valid(rsp_q_valid), .rsp_ready(rsp_q_ready), .rsp_data(rsp_q_data),
        .req_valid(req_q_valid), .req_ready(req_q_ready), .req_data(req_q_data),
        .dma_valid(dma_q_valid), .dma_ready(dma_q_ready), .dma_data(dma_q_data),
        .disp(disp.decoder)
    );

    llc_engine u_engine (
        .clk(clk), .rst(rst),
        .disp(disp.engine),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_kind(out_kind), .out_data(out_data)
    );

endmodule

// File: tests/llc_front_tb.sv
`timescale 1ns/1ns
`include "llc_settings.svh"

module llc_front_tb;

    localparam logic [31:0] SEED = 32'hd488_3c59;
    // each directed test needs well under its budget, the random stream most of its own
    localparam int BASIC_CYCLES  = 200;
    localparam int STREAM_CYCLES = 1200;
    localparam int CYCLE_LIMIT   = 2 * (4 * BASIC_CYCLES + STREAM_CYCLES);

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   rst_cmd_valid, rst_cmd_ready;
    logic                   rsp_valid, rsp_ready, req_valid, req_ready, dma_valid, dma_ready;
    logic [`LLC_MSG_W-1:0]  rsp_data, req_data, dma_data;
    logic                   out_valid, out_ready;
    logic [`LLC_KIND_W-1:0] out_kind;
    logic [`LLC_SET_W+7:0]  out_data;

    logic [14:0] exp_q [$];
    logic [14:0] exp_word;
    logic [7:0]  model_tbl [16];
    logic [31:0] data_lfsr, ready_lfsr;
    logic        stream_done;
    int          errors = 0, checks = 0, cycles = 0;
    int          test_no = 1, errors_at_start = 0, checks_at_start = 0;

    llc_front dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles with %0d outputs still expected",
                     cycles, exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ******************************
    // output checks
    // ******************************

    always @(posedge clk) begin
        if (!rst) begin
            assert (!out_valid) else begin
                $display("Fail %0t: out_valid is high during reset", $time);
                errors++;
            end
        end else if (out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Fail %0t: unexpected output kind %0d data %h", $time, out_kind, out_data);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                checks++;
                assert ({out_kind, out_data} == exp_word) else begin
                    $display("Fail %0t: expected kind %0d data %h, got kind %0d data %h", $time,
                             exp_word[14:12], exp_word[11:0], out_kind, out_data);
                    errors++;
                end
            end
        end
    end

    // ******************************
    // stimulus helpers
    // ******************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic draw(input int n, inout logic [31:0] state, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    task automatic expect_out(input logic [`LLC_KIND_W-1:0] kind, input logic [`LLC_SET_W-1:0] set,
                              input logic [7:0] value);
        exp_q.push_back({kind, set, value});
    endtask

    // all send tasks start and end 10 ns after a rising edge
    task automatic send_req(input logic [1:0] op, input logic [3:0] set, input logic [7:0] value,
                            input bit track);
        if (track) begin
            if (op == 2'd1) begin
                model_tbl[set] = value;
            end
            if (op == 2'd2) begin
                expect_out(`KIND_RECALL_START, set, model_tbl[set]);
            end else begin
                expect_out(`KIND_REQ_ACK, set, model_tbl[set]);
            end
        end
        req_data  = {op, set, 10'h2a5, value};
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        #10;
        req_valid = 1'b0;
    endtask

    task automatic send_rsp(input logic [7:0] value);
        rsp_data  = {2'd0, 4'd0, 10'd0, value};
        rsp_valid = 1'b1;
        @(posedge clk);
        while (!rsp_ready) @(posedge clk);
        #10;
        rsp_valid = 1'b0;
    endtask

    task automatic send_dma(input logic [`LLC_MSG_W-1:0] word);
        dma_data  = word;
        dma_valid = 1'b1;
        @(posedge clk);
        while (!dma_ready) @(posedge clk);
        #10;
        dma_valid = 1'b0;
    endtask

    task automatic send_rst_cmd();
        rst_cmd_valid = 1'b1;
        @(posedge clk);
        while (!rst_cmd_ready) @(posedge clk);
        #10;
        rst_cmd_valid = 1'b0;
    endtask

    task automatic dma_read(input logic [3:0] first, input int beats);
        int i;
        for (i = 0; i < beats; i++) begin
            expect_out(`KIND_DMA_RD_BEAT, 4'(first + i), model_tbl[4'(first + i)]);
        end
        send_dma({1'b0, 3'(beats - 1), first, 16'h0000});
    endtask

    task automatic dma_write(input logic [3:0] first, input int words);
        int i;
        logic [7:0] value;
        value = 8'h00;
        for (i = 0; i < words; i++) begin
            value = 8'(17 * (i + 1) + first);
            model_tbl[4'(first + i)] = value;
        end
        expect_out(`KIND_DMA_WR_ACK, 4'(first + words - 1), value);
        send_dma({1'b1, 3'(words - 1), first, 16'h0000});
        for (i = 0; i < words; i++) begin
            send_dma({16'h0000, model_tbl[4'(first + i)]});
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    task automatic drain();
        do begin
            @(posedge clk);
            #10;
        end while (exp_q.size() != 0);
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s: %0d checks, %0d errors", test_no, name,
                 checks - checks_at_start, errors - errors_at_start);
        test_no++;
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    // ******************************
    // test sequence
    // ******************************

    initial begin
        int i;
        logic [31:0] bits;
        logic [1:0]  rand_op;
        logic [3:0]  rand_set;
        rst = 1'b0;
        rst_cmd_valid = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        req_valid = 1'b0;
        req_data  = '0;
        dma_valid = 1'b0;
        dma_data  = '0;
        out_ready = 1'b1;
        data_lfsr   = SEED;
        ready_lfsr  = SEED;
        stream_done = 1'b0;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b1;

        assert (!out_valid && rsp_ready && req_ready && dma_ready) else begin
            $display("Fail %0t: after reset out_valid %b, readies rsp %b req %b dma %b",
                     $time, out_valid, rsp_ready, req_ready, dma_ready);
            errors++;
        end
        for (i = 0; i < 6; i++) begin
            send_req(2'd1, 4'(i * 3 + 1), 8'(90 + i * 37), 1'b1);
        end
        for (i = 0; i < 6; i++) begin
            send_req(2'd0, 4'(i * 3 + 1), 8'h00, 1'b1);
        end
        drain();
        finish_test("writes then reads");

        // hold the output full so that both commands wait for the same decision
        out_ready = 1'b0;
        send_req(2'd1, 4'd3, 8'ha5, 1'b1);
        while (!out_valid) @(posedge clk);
        #10;
        expect_out(`KIND_RST_DONE, 4'd15, 8'h00);
        for (i = 0; i < 16; i++) begin
            model_tbl[4'(i)] = 8'h00;
        end
        send_req(2'd0, 4'd3, 8'h00, 1'b1);
        fork
            send_rst_cmd();
            begin
                wait_cycles(2);
                out_ready = 1'b1;
            end
        join
        drain();
        finish_test("reset before request");

        send_req(2'd2, 4'd5, 8'h00, 1'b1);
        drain();
        // the read to the recalled set must stay silent until the response
        send_req(2'd0, 4'd5, 8'h00, 1'b0);
        wait_cycles(12);
        model_tbl[5] = 8'hc3;
        expect_out(`KIND_RECALL_DONE, 4'd5, 8'hc3);
        expect_out(`KIND_REQ_ACK, 4'd5, 8'hc3);
        send_rsp(8'hc3);
        drain();
        finish_test("recall and stalled request");

        dma_write(4'd10, 5);
        drain();
        for (i = 0; i < 5; i++) begin
            send_req(2'd0, 4'(10 + i), 8'h00, 1'b1);
        end
        drain();
        dma_read(4'd9, 6);
        dma_read(4'd14, 4);
        drain();
        finish_test("dma write and read");

        fork
            begin
                for (i = 0; i < 150; i++) begin
                    draw(1, data_lfsr, bits);
                    rand_op = {1'b0, bits[0]};
                    draw(4, data_lfsr, bits);
                    rand_set = bits[3:0];
                    draw(8, data_lfsr, bits);
                    send_req(rand_op, rand_set, bits[7:0], 1'b1);
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done || exp_q.size() != 0) begin
                    @(posedge clk);
                    #10;
                    draw(1, ready_lfsr, bits);
                    out_ready = bits[0];
                end
                out_ready = 1'b1;
            end
        join
        // a stray output after the last acknowledge would show here
        wait_cycles(8);
        finish_test("random stream with back-pressure");

        $display("summary: %0d tests, %0d checks, %0d errors", test_no - 1, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: llc_front.f
+incdir+rtl
rtl/llc_pkg.sv
rtl/llc_dispatch_if.sv
rtl/llc_in_fifo.sv
rtl/llc_input_decoder.sv
rtl/llc_engine.sv
rtl/llc_front.sv
tests/llc_front_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := llc_front_tb
FILELIST  := llc_front.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
